// File: logic/weight_pkg.sv
/*
 * weight buffer package
 * tile sizes, bank geometry, widths and FIFO depth shared by the
 * weight FIFO, the loader and the 4 x 4 bank grid
 */

`default_nettype none

package weight_pkg;

    localparam int data_w      = 16;                       // one weight word
    localparam int kernel_dim  = 3;                        // K
    localparam int kernel_size = kernel_dim * kernel_dim;  // 9 words per kernel
    localparam int tile_out_ch = 8;
    localparam int tile_in_ch  = 8;

    // bank grid: row by output channel, column by input channel
    localparam int bank_rows = 4;
    localparam int bank_cols = 4;
    localparam int num_banks = bank_rows * bank_cols;

    localparam int block_size = kernel_size * tile_in_ch;  // words per output channel
    localparam int tile_words = block_size * tile_out_ch;  // 576
    localparam int bank_depth = tile_words / num_banks;    // 36
    localparam int bank_aw    = $clog2(bank_depth);        // 6

    localparam int fifo_depth = 16;
    localparam int fifo_aw    = $clog2(fifo_depth);        // 4

    // must hold the value tile_words itself
    localparam int tile_cw = $clog2(tile_words + 1);       // 10

endpackage

`default_nettype wire

// File: logic/weight_wr_if.sv
/*
 * weight write bus
 * broadcast from the loader to all banks, one-hot bank select
 */

`default_nettype none

interface weight_wr_if;

    logic [weight_pkg::data_w-1:0]    wr_data;
    logic                             wr_valid;
    logic [weight_pkg::num_banks-1:0] wr_bank;     // one-hot target bank
    logic                             tile_clean;  // restarts write pointers

    modport loader (output wr_data, output wr_valid, output wr_bank, output tile_clean);
    modport bank (input wr_data, input wr_valid, input wr_bank, input tile_clean);

endinterface

`default_nettype wire

// File: logic/weight_fifo.sv
/*
 * weight FIFO
 * circular buffer of incoming weight words with registered read data,
 * a push while full is dropped
 */

`default_nettype none

module weight_fifo (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          push,
    input  logic [weight_pkg::data_w-1:0] push_data,
    input  logic                          pop,
    output logic [weight_pkg::data_w-1:0] pop_data,
    output logic                          full,
    output logic                          empty
);

    logic [weight_pkg::data_w-1:0]  mem [weight_pkg::fifo_depth];
    logic [weight_pkg::fifo_aw-1:0] wr_ptr;
    logic [weight_pkg::fifo_aw-1:0] rd_ptr;
    logic [weight_pkg::fifo_aw:0]   count;   // one bit wider than the pointers
    logic                           push_ok;
    logic                           pop_ok;

    assign full    = (count == weight_pkg::fifo_depth);
    assign empty   = (count == 0);
    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;  // wraps at fifo_depth
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage and read register
    always_ff @(posedge clk) begin
        if (push_ok)
            mem[wr_ptr] <= push_data;
        if (pop_ok)
            pop_data <= mem[rd_ptr];  // valid the cycle after the pop
    end

    assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("weight fifo popped while empty");

    assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("weight fifo pushed while full, word dropped");

endmodule

`default_nettype wire

// File: logic/tile_counter.sv
/*
 * kernel and block boundary counter
 * counts loader pops modulo block_size and flags the pop that
 * completes a kernel (9 words) or a block (72 words)
 */

`default_nettype none

module tile_counter (
    input  logic clk,
    input  logic rst,
    input  logic ena,
    input  logic clean,
    output logic kernel_wrap,
    output logic block_wrap
);

    logic [$clog2(weight_pkg::kernel_size)-1:0] kpos;  // position inside the kernel
    logic [$clog2(weight_pkg::block_size)-1:0]  bpos;  // position inside the block

    assign kernel_wrap = ena && (kpos == weight_pkg::kernel_size - 1);
    assign block_wrap  = ena && (bpos == weight_pkg::block_size - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            kpos <= '0;
            bpos <= '0;
        end else if (clean) begin
            kpos <= '0;
            bpos <= '0;
        end else if (ena) begin
            kpos <= kernel_wrap ? '0 : kpos + 1'b1;
            bpos <= block_wrap ? '0 : bpos + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/weight_loader.sv
/*
 * weight loader
 * drains the weight FIFO during a tile load and steers each word to
 * its bank, row by output channel and column by input channel
 */

`default_nettype none

module weight_loader (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          load_start,
    input  logic                          tile_clean,
    input  logic                          fifo_empty,
    input  logic [weight_pkg::data_w-1:0] fifo_data,
    output logic                          fifo_pop,
    output logic                          load_done,
    weight_wr_if.loader                   wr
);

    logic                                      load_active;
    logic [weight_pkg::tile_cw-1:0]            word_cnt;    // pops so far in this tile
    logic                                      kernel_wrap;
    logic                                      block_wrap;
    logic [$clog2(weight_pkg::bank_cols)-1:0]  col_idx;     // input channel mod 4
    logic [$clog2(weight_pkg::bank_rows)-1:0]  row_idx;     // output channel mod 4
    logic [weight_pkg::num_banks-1:0]          sel_onehot;

    // a full tile stops popping, load_done follows one edge later
    assign fifo_pop = load_active && !fifo_empty
                      && (word_cnt != weight_pkg::tile_words);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_active <= 1'b0;
            word_cnt    <= '0;
            load_done   <= 1'b0;
        end else if (tile_clean) begin
            load_active <= 1'b0;
            word_cnt    <= '0;
            load_done   <= 1'b0;
        end else begin
            if (load_start)
                load_active <= 1'b1;
            else if (load_done)
                load_active <= 1'b0;
            if (fifo_pop)
                word_cnt <= word_cnt + 1'b1;
            if (word_cnt == weight_pkg::tile_words)
                load_done <= 1'b1;  // same edge as the last write
        end
    end

    tile_counter u_tile_counter (
        .clk         (clk),
        .rst         (rst),
        .ena         (fifo_pop),
        .clean       (tile_clean),
        .kernel_wrap (kernel_wrap),
        .block_wrap  (block_wrap)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            col_idx <= '0;
            row_idx <= '0;
        end else if (tile_clean) begin
            col_idx <= '0;
            row_idx <= '0;
        end else begin
            if (kernel_wrap)
                col_idx <= (col_idx == weight_pkg::bank_cols - 1) ? '0 : col_idx + 1'b1;
            if (block_wrap)
                row_idx <= (row_idx == weight_pkg::bank_rows - 1) ? '0 : row_idx + 1'b1;
        end
    end

    // bank number is row * bank_cols + col
    always_comb begin
        sel_onehot = '0;
        sel_onehot[{row_idx, col_idx}] = 1'b1;
    end

    // select travels with the delayed pop so the write follows its word
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr.wr_valid <= 1'b0;
            wr.wr_bank  <= '0;
        end else if (tile_clean) begin
            wr.wr_valid <= 1'b0;
            wr.wr_bank  <= '0;
        end else begin
            wr.wr_valid <= fifo_pop;
            wr.wr_bank  <= fifo_pop ? sel_onehot : '0;
        end
    end

    assign wr.wr_data    = fifo_data;   // FIFO read register
    assign wr.tile_clean = tile_clean;

    assert property (@(posedge clk) disable iff (rst) load_done |-> !fifo_pop)
        else $error("weight fifo popped after load done");

endmodule

`default_nettype wire

// File: logic/weight_bank.sv
/*
 * weight bank
 * one bank_depth word RAM filled in arrival order by its own write
 * pointer, with one registered read port
 */

`default_nettype none

module weight_bank (
    input  logic                           clk,
    input  logic                           rst,
    weight_wr_if.bank                      wr,
    input  logic                           bank_sel,  // this bank's bit of wr_bank
    input  logic [weight_pkg::bank_aw-1:0] rd_addr,
    output logic [weight_pkg::data_w-1:0]  rd_data
);

    logic [weight_pkg::data_w-1:0]  mem [weight_pkg::bank_depth];
    logic [weight_pkg::bank_aw-1:0] wr_ptr;
    logic                           wr_en;

    assign wr_en = wr.wr_valid && bank_sel;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            wr_ptr <= '0;
        else if (wr.tile_clean)
            wr_ptr <= '0;            // contents stay, only the pointer restarts
        else if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= wr.wr_data;
    end

    // read port runs independently of writes
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    assert property (@(posedge clk) disable iff (rst) wr_en |-> wr_ptr < weight_pkg::bank_depth)
        else $error("weight bank overflow, more than bank_depth words in a tile");

endmodule

`default_nettype wire

// File: logic/weight_buffer_top.sv
/*
 * weight buffer top
 * weight FIFO, loader and a 4 x 4 grid of weight banks,
 * each bank with its own read port
 */

`default_nettype none

module weight_buffer_top (
    input  logic                                                         clk,
    input  logic                                                         rst,
    input  logic                                                         weight_push,
    input  logic [weight_pkg::data_w-1:0]                                weight_data,
    output logic                                                         weight_full,
    input  logic                                                         load_start,
    output logic                                                         load_done,
    input  logic                                                         tile_clean,
    input  logic [weight_pkg::num_banks-1:0][weight_pkg::bank_aw-1:0]    rd_addr,
    output logic [weight_pkg::num_banks-1:0][weight_pkg::data_w-1:0]     rd_data
);

    logic                          fifo_pop;
    logic                          fifo_empty;
    logic [weight_pkg::data_w-1:0] fifo_data;

    weight_wr_if wr_bus ();

    weight_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (weight_push),
        .push_data (weight_data),
        .pop       (fifo_pop),
        .pop_data  (fifo_data),
        .full      (weight_full),
        .empty     (fifo_empty)
    );

    weight_loader u_loader (
        .clk        (clk),
        .rst        (rst),
        .load_start (load_start),
        .tile_clean (tile_clean),
        .fifo_empty (fifo_empty),
        .fifo_data  (fifo_data),
        .fifo_pop   (fifo_pop),
        .load_done  (load_done),
        .wr         (wr_bus.loader)
    );

    // bank i sits at row i / bank_cols and column i % bank_cols
    for (genvar i = 0; i < weight_pkg::num_banks; i++) begin : g_bank
        weight_bank u_bank (
            .clk      (clk),
            .rst      (rst),
            .wr       (wr_bus.bank),
            .bank_sel (wr_bus.wr_bank[i]),
            .rd_addr  (rd_addr[i]),
            .rd_data  (rd_data[i])
        );
    end

endmodule

`default_nettype wire

// File: verif/weight_buffer_tb.sv
/*
 * weight buffer testbench
 * seeded random weight stream through FIFO, loader and bank grid,
 * readback of every bank checked against the channel to bank mapping
 */

`default_nettype none

module weight_buffer_tb;

    localparam int clk_period      = 40;
    localparam int watchdog_cycles = 2 * (2 * weight_pkg::tile_words * 3);

    logic                                                      clk;
    logic                                                      rst;
    logic                                                      weight_push;
    logic [weight_pkg::data_w-1:0]                             weight_data;
    logic                                                      weight_full;
    logic                                                      load_start;
    logic                                                      load_done;
    logic                                                      tile_clean;
    logic [weight_pkg::num_banks-1:0][weight_pkg::bank_aw-1:0] rd_addr;
    logic [weight_pkg::num_banks-1:0][weight_pkg::data_w-1:0]  rd_data;

    logic [weight_pkg::data_w-1:0] ref_mem [weight_pkg::num_banks][weight_pkg::bank_depth];
    logic [weight_pkg::data_w-1:0] pushed [$];   // every accepted word in push order
    int                            seed;
    int                            passes;
    int                            fails;
    int                            fails_before;

    weight_buffer_top uut (
        .clk         (clk),
        .rst         (rst),
        .weight_push (weight_push),
        .weight_data (weight_data),
        .weight_full (weight_full),
        .load_start  (load_start),
        .load_done   (load_done),
        .tile_clean  (tile_clean),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    always #(clk_period / 2) clk = ~clk;

    assert property (@(posedge clk) disable iff (rst) load_done && !tile_clean |=> load_done)
        else begin
            fails++;
            $display("load_done fell without a tile_clean pulse");
        end

    assert property (@(posedge clk) disable iff (rst) tile_clean |=> !load_done)
        else begin
            fails++;
            $display("load_done still high after tile_clean");
        end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) begin
            passes++;
        end else begin
            fails++;
            $display("mismatch %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s: %s", name, (fails == fails_before) ? "ok" : "failed");
        fails_before = fails;
    endtask

    // called on a falling edge, returns on the falling edge after the push
    task automatic push_word(input logic [weight_pkg::data_w-1:0] value);
        weight_push = 1'b0;
        while (weight_full)
            @(negedge clk);
        weight_push = 1'b1;
        weight_data = value;
        pushed.push_back(value);
        @(negedge clk);
        weight_push = 1'b0;
    endtask

    task automatic push_with_gaps(input int count);
        for (int i = 0; i < count; i++) begin
            push_word(weight_pkg::data_w'($random(seed)));
            if (($random(seed) & 3) == 0)
                repeat (1 + ($random(seed) & 3)) @(negedge clk);  // idle gap
        end
    endtask

    task automatic pulse_load_start();
        load_start = 1'b1;
        @(negedge clk);
        load_start = 1'b0;
    endtask

    // tile word n goes to row m mod 4, column c mod 4
    task automatic build_model(input int base);
        int p;
        int c;
        int m;
        int bank;
        int addr;
        for (int n = 0; n < weight_pkg::tile_words; n++) begin
            p    = n % 9;
            c    = (n / 9) % 8;
            m    = n / 72;
            bank = (m % 4) * 4 + (c % 4);
            addr = ((m / 4) * 2 + (c / 4)) * 9 + p;
            ref_mem[bank][addr] = pushed[base + n];
        end
    endtask

    task automatic read_back(input string name);
        for (int a = 0; a < weight_pkg::bank_depth; a++) begin
            for (int b = 0; b < weight_pkg::num_banks; b++)
                rd_addr[b] = weight_pkg::bank_aw'(a);
            @(negedge clk);  // data registered on the rising edge between
            for (int b = 0; b < weight_pkg::num_banks; b++)
                check_value($sformatf("%s bank %0d addr %0d", name, b, a),
                            ref_mem[b][a], rd_data[b]);
        end
    endtask

    initial begin
        int accepted;
        clk          = 1'b0;
        rst          = 1'b1;
        weight_push  = 1'b0;
        weight_data  = '0;
        load_start   = 1'b0;
        tile_clean   = 1'b0;
        rd_addr      = '0;
        seed         = 32'hada9_5536;
        passes       = 0;
        fails        = 0;
        fails_before = 0;
        accepted     = 0;

        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("reset load_done", 0, load_done);
        check_value("reset weight_full", 0, weight_full);
        report_test("reset_state");

        // loader idle, so the FIFO only fills
        while (!weight_full && accepted <= weight_pkg::fifo_depth) begin
            push_word(weight_pkg::data_w'($random(seed)));
            accepted++;
        end
        check_value("backpressure accepted", weight_pkg::fifo_depth, accepted);
        report_test("back_pressure");

        pulse_load_start();
        push_with_gaps(weight_pkg::tile_words - weight_pkg::fifo_depth);
        while (!load_done)
            @(negedge clk);
        build_model(0);
        read_back("full_tile");
        report_test("full_tile");

        // these words become the head of the next tile
        repeat (weight_pkg::fifo_depth) push_word(weight_pkg::data_w'($random(seed)));
        repeat (4) @(negedge clk);
        check_value("sticky weight_full", 1, weight_full);
        check_value("sticky load_done", 1, load_done);
        report_test("done_sticky");

        tile_clean = 1'b1;
        @(negedge clk);
        tile_clean = 1'b0;
        check_value("clean load_done", 0, load_done);
        pulse_load_start();
        push_with_gaps(weight_pkg::tile_words - weight_pkg::fifo_depth);
        while (!load_done)
            @(negedge clk);
        build_model(weight_pkg::tile_words);
        read_back("second_tile");
        report_test("second_tile");

        $display("checks passed %0d, failed %0d", passes, fails);
        if (fails == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // two tiles at up to three cycles per word, with a factor of two margin
    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout: the tests did not finish in %0d clock cycles", watchdog_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
logic/weight_pkg.sv
logic/weight_wr_if.sv
logic/weight_fifo.sv
logic/tile_counter.sv
logic/weight_loader.sv
logic/weight_bank.sv
logic/weight_buffer_top.sv
verif/weight_buffer_tb.sv
